/* source/l2_config_pkg.sv */
/*
 * Cache geometry constants, vector types for addresses, tags, sets and lines,
 * and the helpers that split a word address into its set and tag
 */
package l2_config_pkg;
	localparam int addr_bits = 12;
	localparam int l2_set_bits = 4;
	localparam int l2_num_sets = 1 << l2_set_bits;
	localparam int l1_set_bits = 3;
	localparam int l1_num_sets = 1 << l1_set_bits;
	localparam int l1_num_ways = 2;
	localparam int num_cores = 2;
	localparam int default_l2_ways = 2;

	typedef logic [addr_bits - 1:0] addr_t;
	typedef logic [l2_set_bits - 1:0] l2_set_t;
	typedef logic [addr_bits - l2_set_bits - 1:0] l2_tag_t;
	typedef logic [l1_set_bits - 1:0] l1_set_t;
	typedef logic [addr_bits - l1_set_bits - 1:0] l1_tag_t;
	typedef logic [31:0] line_t;
	typedef logic [$clog2(num_cores) - 1:0] core_t;
	typedef logic [$clog2(l1_num_ways) - 1:0] l1_way_t;

	// The set index is the low part of the word address, the tag is the rest
	function automatic l2_set_t l2_set_of(addr_t address);
		return address[l2_set_bits - 1:0];
	endfunction

	function automatic l2_tag_t l2_tag_of(addr_t address);
		return address[addr_bits - 1:l2_set_bits];
	endfunction

	// The L1 data cache has fewer sets, so its tag is one bit wider
	function automatic l1_set_t l1_set_of(addr_t address);
		return address[l1_set_bits - 1:0];
	endfunction

	function automatic l1_tag_t l1_tag_of(addr_t address);
		return address[addr_bits - 1:l1_set_bits];
	endfunction
endpackage

/* source/l2_request_pkg.sv */
/*
 * Operation and unit encodings, plus the request and response packets
 * exchanged with the L1 caches
 */
package l2_request_pkg;
	typedef enum logic [1:0]
	{
		op_load,
		op_store,
		op_flush,
		op_dinvalidate
	} l2_op_t;

	// Which L1 cache of the core sent the request
	typedef enum logic
	{
		unit_icache,
		unit_dcache
	} unit_t;

	// A fill is the same load or store sent again with the memory data
	// in the data field and is_fill set
	typedef struct packed
	{
		l2_op_t op;
		unit_t unit;
		l2_config_pkg::core_t core;
		l2_config_pkg::l1_way_t l1_way;
		l2_config_pkg::addr_t address;
		l2_config_pkg::line_t data;
		logic is_fill;
	} l2_request_t;

	// One response per request, returned in request order
	typedef struct packed
	{
		l2_config_pkg::core_t core;
		l2_op_t op;
		logic hit;
		l2_config_pkg::line_t data;
		// Set when a dirty victim line has to go back to memory
		logic writeback;
		l2_config_pkg::addr_t writeback_address;
		l2_config_pkg::line_t writeback_data;
		// Requesting core had the line in its L1 data cache at an invalidate
		logic l1_had_line;
	} l2_response_t;
endpackage

/* source/l2_request_in.sv */
/*
 * One-entry input buffer between the request handshake and the pipeline
 */
`timescale 1ns/1ns

module l2_request_in(
	input clk,
	input reset,
	input l2_request_pkg::l2_request_t request,
	input request_valid,
	output logic request_ready,
	input advance,
	output l2_request_pkg::l2_request_t in_request,
	output logic in_valid);

	logic load_slot;

	// The slot takes a new request when it is empty or its request moves
	// into the tag stage on this edge
	assign load_slot = !in_valid || advance;
	assign request_ready = load_slot;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			in_valid <= 1'b0;
		else if (load_slot)
			in_valid <= request_valid;
	end

	// Request payload held in the slot until the tag stage takes it
	always_ff @(posedge clk)
	begin
		if (load_slot)
			in_request <= request;
	end
endmodule

/* source/l2_cache_tag.sv */
/*
 * L2 tag stage with tag, valid, dirty, replacement and L1 directory arrays,
 * lookup of the incoming request and forwarding of same-cycle updates
 */
`timescale 1ns/1ns

module l2_cache_tag #(
	parameter int l2_ways = l2_config_pkg::default_l2_ways,
	localparam int way_bits = (l2_ways > 1) ? $clog2(l2_ways) : 1)
(
	input clk,
	input reset,
	input advance,
	input l2_request_pkg::l2_request_t in_request,
	input in_valid,
	input update_tag_enable,
	input l2_config_pkg::l2_set_t update_tag_set,
	input [way_bits - 1:0] update_tag_way,
	input l2_config_pkg::l2_tag_t update_tag_tag,
	input update_tag_valid,
	input l2_config_pkg::l2_set_t update_dirty_set,
	input [l2_ways - 1:0] update_dirty_mask,
	input new_dirty,
	input update_directory,
	input l2_config_pkg::core_t update_dir_core,
	input l2_config_pkg::l1_set_t update_dir_set,
	input l2_config_pkg::l1_way_t update_dir_way,
	input l2_config_pkg::l1_tag_t update_dir_tag,
	input update_dir_valid,
	output l2_request_pkg::l2_request_t tag_request,
	output logic tag_valid_out,
	output l2_config_pkg::l2_tag_t [l2_ways - 1:0] tag_l2_tag,
	output logic [l2_ways - 1:0] tag_l2_valid,
	output logic [l2_ways - 1:0] tag_l2_dirty,
	output logic [way_bits - 1:0] tag_miss_fill_way,
	output logic tag_l1_has_line,
	output l2_config_pkg::l1_way_t tag_l1_way);

	import l2_config_pkg::*;

	l2_tag_t tag_array [l2_ways][l2_num_sets];
	logic [l2_ways - 1:0] valid_array [l2_num_sets];
	logic [l2_ways - 1:0] dirty_array [l2_num_sets];
	logic [way_bits - 1:0] replace_ptr [l2_num_sets];
	l1_tag_t l1_tag_array [num_cores][l1_num_sets][l1_num_ways];
	logic [l1_num_ways - 1:0] l1_valid_array [num_cores][l1_num_sets];

	l2_set_t req_set;
	l1_set_t req_l1_set;
	l1_tag_t req_l1_tag;
	l2_tag_t [l2_ways - 1:0] set_tags;
	logic [l2_ways - 1:0] set_valid;
	logic [l2_ways - 1:0] set_dirty;
	logic [way_bits - 1:0] set_ptr;
	l1_tag_t [l1_num_ways - 1:0] l1_tags;
	logic [l1_num_ways - 1:0] l1_valid;
	logic [way_bits - 1:0] fill_way;
	logic l1_has_line;
	l1_way_t l1_way;

	// Round-robin step that also wraps for a way count that is not a power of two
	function automatic logic [way_bits - 1:0] ptr_step(logic [way_bits - 1:0] ptr);
		if (ptr == way_bits'(l2_ways - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign req_set = l2_set_of(in_request.address);
	assign req_l1_set = l1_set_of(in_request.address);
	assign req_l1_tag = l1_tag_of(in_request.address);

	always_comb
	begin
		// Stored state of the requested set
		for (int w = 0; w < l2_ways; w++)
			set_tags[w] = tag_array[w][req_set];
		set_valid = valid_array[req_set];
		set_dirty = dirty_array[req_set];
		set_ptr = replace_ptr[req_set];
		for (int v = 0; v < l1_num_ways; v++)
			l1_tags[v] = l1_tag_array[in_request.core][req_l1_set][v];
		l1_valid = l1_valid_array[in_request.core][req_l1_set];

		// The dir stage writes these at the same edge that registers this lookup,
		// so merge its updates in here or the next request would see stale state
		if (update_tag_enable && update_tag_set == req_set)
		begin
			set_tags[update_tag_way] = update_tag_tag;
			set_valid[update_tag_way] = update_tag_valid;
			if (update_tag_valid)
				set_ptr = ptr_step(set_ptr);
		end
		if (update_dirty_set == req_set)
			set_dirty = (set_dirty & ~update_dirty_mask) | ({l2_ways{new_dirty}} & update_dirty_mask);
		if (update_directory && update_dir_core == in_request.core && update_dir_set == req_l1_set)
		begin
			l1_tags[update_dir_way] = update_dir_tag;
			l1_valid[update_dir_way] = update_dir_valid;
		end

		// Lowest invalid way wins, the replacement pointer only when the set is full
		fill_way = set_ptr;
		for (int w = l2_ways - 1; w >= 0; w--)
		begin
			if (!set_valid[w])
				fill_way = way_bits'(w);
		end

		// Does the requesting core hold this line in either L1 way
		l1_has_line = 1'b0;
		l1_way = '0;
		for (int v = 0; v < l1_num_ways; v++)
		begin
			if (l1_valid[v] && l1_tags[v] == req_l1_tag)
			begin
				l1_has_line = 1'b1;
				l1_way = l1_way_t'(v);
			end
		end
	end

	// Control bits of the arrays, written by the dir stage
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < l2_num_sets; s++)
			begin
				valid_array[s] <= '0;
				dirty_array[s] <= '0;
				replace_ptr[s] <= '0;
			end
			for (int c = 0; c < num_cores; c++)
			begin
				for (int s = 0; s < l1_num_sets; s++)
					l1_valid_array[c][s] <= '0;
			end
			tag_valid_out <= 1'b0;
		end
		else if (advance)
		begin
			if (update_tag_enable)
			begin
				valid_array[update_tag_set][update_tag_way] <= update_tag_valid;
				// Every fill into the set moves its pointer on
				if (update_tag_valid)
					replace_ptr[update_tag_set] <= ptr_step(replace_ptr[update_tag_set]);
			end
			dirty_array[update_dirty_set] <= (dirty_array[update_dirty_set] & ~update_dirty_mask)
				| ({l2_ways{new_dirty}} & update_dirty_mask);
			if (update_directory)
				l1_valid_array[update_dir_core][update_dir_set][update_dir_way] <= update_dir_valid;
			tag_valid_out <= in_valid;
		end
	end

	// Tag storage and the lookup result register
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			if (update_tag_enable)
				tag_array[update_tag_way][update_tag_set] <= update_tag_tag;
			if (update_directory)
				l1_tag_array[update_dir_core][update_dir_set][update_dir_way] <= update_dir_tag;
			tag_request <= in_request;
			tag_l2_tag <= set_tags;
			tag_l2_valid <= set_valid;
			tag_l2_dirty <= set_dirty;
			tag_miss_fill_way <= fill_way;
			tag_l1_has_line <= l1_has_line;
			tag_l1_way <= l1_way;
		end
	end
endmodule

/* source/l2_cache_dir.sv */
/*
 * L2 directory stage with hit detection, victim selection and the tag,
 * dirty and L1 directory updates sent back to the tag stage
 */
`timescale 1ns/1ns

module l2_cache_dir #(
	parameter int l2_ways = l2_config_pkg::default_l2_ways,
	localparam int way_bits = (l2_ways > 1) ? $clog2(l2_ways) : 1)
(
	input clk,
	input reset,
	input advance,
	input l2_request_pkg::l2_request_t tag_request,
	input tag_valid_out,
	input l2_config_pkg::l2_tag_t [l2_ways - 1:0] tag_l2_tag,
	input [l2_ways - 1:0] tag_l2_valid,
	input [l2_ways - 1:0] tag_l2_dirty,
	input [way_bits - 1:0] tag_miss_fill_way,
	input tag_l1_has_line,
	input l2_config_pkg::l1_way_t tag_l1_way,
	output logic update_tag_enable,
	output l2_config_pkg::l2_set_t update_tag_set,
	output logic [way_bits - 1:0] update_tag_way,
	output l2_config_pkg::l2_tag_t update_tag_tag,
	output logic update_tag_valid,
	output l2_config_pkg::l2_set_t update_dirty_set,
	output logic [l2_ways - 1:0] update_dirty_mask,
	output logic new_dirty,
	output logic update_directory,
	output l2_config_pkg::core_t update_dir_core,
	output l2_config_pkg::l1_set_t update_dir_set,
	output l2_config_pkg::l1_way_t update_dir_way,
	output l2_config_pkg::l1_tag_t update_dir_tag,
	output logic update_dir_valid,
	output l2_request_pkg::l2_request_t dir_request,
	output logic dir_valid,
	output logic dir_cache_hit,
	output logic [way_bits - 1:0] dir_hit_way,
	output logic [way_bits - 1:0] dir_fill_way,
	output logic dir_is_fill,
	output l2_config_pkg::l2_tag_t dir_old_tag,
	output logic dir_victim_dirty,
	output logic dir_l1_had_line);

	import l2_config_pkg::*;
	import l2_request_pkg::*;

	l2_tag_t requested_tag;
	logic [l2_ways - 1:0] hit_way_oh;
	logic cache_hit;
	logic [way_bits - 1:0] hit_way;
	logic [way_bits - 1:0] victim_way;
	logic is_fill;
	logic is_store;
	logic is_flush;
	logic is_invalidate;
	logic is_dcache_load;
	logic update_dirty;

	assign requested_tag = l2_tag_of(tag_request.address);
	assign is_fill = tag_request.is_fill;
	assign is_store = tag_request.op == op_store;
	assign is_flush = tag_request.op == op_flush;
	assign is_invalidate = tag_request.op == op_dinvalidate;
	assign is_dcache_load = tag_request.op == op_load && tag_request.unit == unit_dcache;

	// A way hits when it is valid and holds the requested tag
	always_comb
	begin
		for (int w = 0; w < l2_ways; w++)
			hit_way_oh[w] = tag_l2_valid[w] && tag_l2_tag[w] == requested_tag;
	end

	assign cache_hit = |hit_way_oh;

	// OR of the indices of set bits, which is exact while the match is one-hot
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < l2_ways; w++)
		begin
			if (hit_way_oh[w])
				hit_way = hit_way | way_bits'(w);
		end
	end

	// A fill replaces the fill way; a flush writes back the line it hit
	assign victim_way = is_fill ? tag_miss_fill_way : hit_way;

	// Tag and valid change on a fill, or on an invalidate of a line that is present
	assign update_tag_enable = tag_valid_out && (is_fill || (is_invalidate && cache_hit));
	assign update_tag_set = l2_set_of(tag_request.address);
	assign update_tag_way = is_invalidate ? hit_way : tag_miss_fill_way;
	assign update_tag_tag = requested_tag;
	assign update_tag_valid = !is_invalidate;

	// Dirty bits move on a fill, a store hit or a flush hit
	assign update_dirty = tag_valid_out && (is_fill || (cache_hit && (is_store || is_flush)));
	assign update_dirty_set = l2_set_of(tag_request.address);

	always_comb
	begin
		for (int w = 0; w < l2_ways; w++)
		begin
			update_dirty_mask[w] = update_dirty
				&& (is_fill ? tag_miss_fill_way == way_bits'(w) : hit_way_oh[w]);
		end

		// A filled line is dirty only when the store that caused it lands in it
		if (is_fill)
			new_dirty = is_store;
		else if (is_flush)
			new_dirty = 1'b0;
		else
			new_dirty = 1'b1;
	end

	// The directory tracks lines pushed to the L1 data caches, which only
	// happens for data loads; stores do not allocate in L1
	assign update_directory = tag_valid_out
		&& ((is_dcache_load && (cache_hit || is_fill)) || (is_invalidate && tag_l1_has_line));
	assign update_dir_core = tag_request.core;
	assign update_dir_set = l1_set_of(tag_request.address);
	assign update_dir_way = is_invalidate ? tag_l1_way : tag_request.l1_way;
	assign update_dir_tag = l1_tag_of(tag_request.address);
	assign update_dir_valid = !is_invalidate;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dir_valid <= 1'b0;
		else if (advance)
			dir_valid <= tag_valid_out;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			dir_request <= tag_request;
			dir_cache_hit <= cache_hit;
			dir_hit_way <= hit_way;
			dir_fill_way <= tag_miss_fill_way;
			dir_is_fill <= is_fill;
			dir_old_tag <= tag_l2_tag[victim_way];
			dir_victim_dirty <= tag_l2_dirty[victim_way] && tag_l2_valid[victim_way];
			dir_l1_had_line <= tag_l1_has_line;
		end
	end
endmodule

/* source/l2_cache_read.sv */
/*
 * L2 read stage holding the line data, with fill and store writes,
 * writeback capture and the response register
 */
`timescale 1ns/1ns

module l2_cache_read #(
	parameter int l2_ways = l2_config_pkg::default_l2_ways,
	localparam int way_bits = (l2_ways > 1) ? $clog2(l2_ways) : 1)
(
	input clk,
	input reset,
	input advance,
	input l2_request_pkg::l2_request_t dir_request,
	input dir_valid,
	input dir_cache_hit,
	input [way_bits - 1:0] dir_hit_way,
	input [way_bits - 1:0] dir_fill_way,
	input dir_is_fill,
	input l2_config_pkg::l2_tag_t dir_old_tag,
	input dir_victim_dirty,
	input dir_l1_had_line,
	output l2_request_pkg::l2_response_t response,
	output logic response_valid);

	import l2_config_pkg::*;
	import l2_request_pkg::*;

	line_t data_array [l2_ways][l2_num_sets];

	l2_set_t req_set;
	logic [way_bits - 1:0] read_way;
	line_t read_line;
	logic store_hit;
	l2_response_t next_response;

	assign req_set = l2_set_of(dir_request.address);

	// On a fill this is the victim about to be overwritten, otherwise the hit line
	assign read_way = dir_is_fill ? dir_fill_way : dir_hit_way;
	assign read_line = data_array[read_way][req_set];
	assign store_hit = dir_request.op == op_store && dir_cache_hit && !dir_is_fill;

	always_comb
	begin
		next_response.core = dir_request.core;
		next_response.op = dir_request.op;
		next_response.hit = dir_cache_hit;

		// A fill answers with the memory data, a store with what it wrote
		if (dir_is_fill || dir_request.op == op_store)
			next_response.data = dir_request.data;
		else if (dir_cache_hit)
			next_response.data = read_line;
		else
			next_response.data = '0;

		// Dirty victim of a fill, or a dirty line hit by a flush
		next_response.writeback = dir_victim_dirty
			&& (dir_is_fill || (dir_request.op == op_flush && dir_cache_hit));
		if (next_response.writeback)
		begin
			next_response.writeback_address = {dir_old_tag, req_set};
			next_response.writeback_data = read_line;
		end
		else
		begin
			next_response.writeback_address = '0;
			next_response.writeback_data = '0;
		end

		next_response.l1_had_line = dir_l1_had_line && dir_request.op == op_dinvalidate;
	end

	// Line data, written after the old contents have been captured above
	always_ff @(posedge clk)
	begin
		if (advance && dir_valid)
		begin
			if (dir_is_fill)
				data_array[dir_fill_way][req_set] <= dir_request.data;
			else if (store_hit)
				data_array[dir_hit_way][req_set] <= dir_request.data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			response_valid <= 1'b0;
		else if (advance)
			response_valid <= dir_valid;
	end

	// Held while the consumer is not ready, since advance is then low
	always_ff @(posedge clk)
	begin
		if (advance)
			response <= next_response;
	end
endmodule

/* source/l2_cache.sv */
/*
 * L2 cache top level with the input buffer, tag, dir and read stages
 * and the pipeline-wide stall
 */
`timescale 1ns/1ns

module l2_cache #(
	parameter int l2_ways = l2_config_pkg::default_l2_ways)
(
	input clk,
	input reset,
	input l2_request_pkg::l2_request_t request,
	input request_valid,
	output logic request_ready,
	output l2_request_pkg::l2_response_t response,
	output logic response_valid,
	input response_ready);

	import l2_config_pkg::*;
	import l2_request_pkg::*;

	localparam int way_bits = (l2_ways > 1) ? $clog2(l2_ways) : 1;

	logic advance;

	// Input buffer to tag stage
	l2_request_t in_request;
	logic in_valid;

	// Tag stage to dir stage
	l2_request_t tag_request;
	logic tag_valid_out;
	l2_tag_t [l2_ways - 1:0] tag_l2_tag;
	logic [l2_ways - 1:0] tag_l2_valid;
	logic [l2_ways - 1:0] tag_l2_dirty;
	logic [way_bits - 1:0] tag_miss_fill_way;
	logic tag_l1_has_line;
	l1_way_t tag_l1_way;

	// Updates from the dir stage back into the tag stage arrays
	logic update_tag_enable;
	l2_set_t update_tag_set;
	logic [way_bits - 1:0] update_tag_way;
	l2_tag_t update_tag_tag;
	logic update_tag_valid;
	l2_set_t update_dirty_set;
	logic [l2_ways - 1:0] update_dirty_mask;
	logic new_dirty;
	logic update_directory;
	core_t update_dir_core;
	l1_set_t update_dir_set;
	l1_way_t update_dir_way;
	l1_tag_t update_dir_tag;
	logic update_dir_valid;

	// Dir stage to read stage
	l2_request_t dir_request;
	logic dir_valid;
	logic dir_cache_hit;
	logic [way_bits - 1:0] dir_hit_way;
	logic [way_bits - 1:0] dir_fill_way;
	logic dir_is_fill;
	l2_tag_t dir_old_tag;
	logic dir_victim_dirty;
	logic dir_l1_had_line;

	// The whole pipeline freezes while a response waits for the consumer
	assign advance = !(response_valid && !response_ready);

	l2_request_in request_in(.*);

	l2_cache_tag #(.l2_ways(l2_ways)) tag_stage(.*);

	l2_cache_dir #(.l2_ways(l2_ways)) dir_stage(.*);

	l2_cache_read #(.l2_ways(l2_ways)) read_stage(.*);
endmodule

/* testbench/l2_cache_asserts.sv */
/*
 * Handshake and pipeline assertions for the L2 cache, bound to its top level
 */
`timescale 1ns/1ns

module l2_cache_asserts #(
	parameter int l2_ways = l2_config_pkg::default_l2_ways)
(
	input clk,
	input reset,
	input request_valid,
	input request_ready,
	input l2_request_pkg::l2_response_t response,
	input response_valid,
	input response_ready,
	input [l2_ways - 1:0] hit_way_oh);

	logic [3:0] in_flight;

	// Requests accepted but not yet answered
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			in_flight <= '0;
		else
			in_flight <= in_flight + 4'(request_valid && request_ready)
				- 4'(response_valid && response_ready);
	end

	// A stalled response keeps its valid and its contents until taken
	response_held: assert property (@(posedge clk) disable iff (reset)
		response_valid && !response_ready |=> response_valid && $stable(response))
		else $error("response changed while waiting for ready");

	response_has_request: assert property (@(posedge clk) disable iff (reset)
		response_valid |-> in_flight != 0)
		else $error("response valid with no request in flight");

	// At most one way may hold the requested tag
	hit_one_hot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(hit_way_oh))
		else $error("more than one way matched the requested tag");
endmodule

bind l2_cache l2_cache_asserts #(.l2_ways(l2_ways)) protocol_checks(
	.clk(clk),
	.reset(reset),
	.request_valid(request_valid),
	.request_ready(request_ready),
	.response(response),
	.response_valid(response_valid),
	.response_ready(response_ready),
	.hit_way_oh(dir_stage.hit_way_oh));

/* testbench/l2_cache_tb.sv */
/*
 * Testbench for the L2 cache with requests read from a stimulus file, random
 * idle gaps and back-pressure, in-order response checks and a cycle limit
 */
`timescale 1ns/1ns

module l2_cache_tb;
	import l2_config_pkg::*;
	import l2_request_pkg::*;

	logic clk = 1'b0;
	logic reset = 1'b1;
	l2_request_t request = '0;
	logic request_valid = 1'b0;
	logic request_ready;
	l2_response_t response;
	logic response_valid;
	logic response_ready = 1'b0;

	// Requests and expected responses as read from the file, one entry per line
	l2_request_t stim_request [$];
	l2_response_t stim_expected [$];
	logic stim_burst [$];

	// Responses still owed by the DUT, oldest first
	l2_response_t expected_queue [$];

	logic [31:0] lfsr_state = 32'hf849;
	logic [1:0] idle_draw = 2'b00;
	int line_count = 0;
	int responses_seen = 0;
	int cycle_count = 0;
	int cycle_limit = 100;

	l2_cache #(.l2_ways(default_l2_ways)) uut(.*);

	always #4 clk = ~clk;

	// Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function logic take_random_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// Names the first field that differs, or gives an empty string
	function automatic string describe_mismatch(l2_response_t got, l2_response_t expected);
		if (got.core != expected.core)
			return $sformatf("core got %0h expected %0h", got.core, expected.core);
		if (got.op != expected.op)
			return $sformatf("op got %0h expected %0h", got.op, expected.op);
		if (got.hit != expected.hit)
			return $sformatf("hit got %0h expected %0h", got.hit, expected.hit);
		if (got.data != expected.data)
			return $sformatf("data got %h expected %h", got.data, expected.data);
		if (got.writeback != expected.writeback)
			return $sformatf("writeback got %0h expected %0h", got.writeback, expected.writeback);
		if (got.writeback_address != expected.writeback_address)
			return $sformatf("writeback_address got %h expected %h",
				got.writeback_address, expected.writeback_address);
		if (got.writeback_data != expected.writeback_data)
			return $sformatf("writeback_data got %h expected %h",
				got.writeback_data, expected.writeback_data);
		if (got.l1_had_line != expected.l1_had_line)
			return $sformatf("l1_had_line got %0h expected %0h",
				got.l1_had_line, expected.l1_had_line);
		return "";
	endfunction

	// Lines that do not hold all fourteen hex fields are comments and get skipped
	task automatic load_stimulus();
		int fd;
		logic [8 * 256 - 1:0] text;
		logic [31:0] f [14];
		l2_request_t req;
		l2_response_t exp;
		fd = $fopen("testbench/l2_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("The stimulus file testbench/l2_stimulus.txt could not be opened");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
		while ($fgets(text, fd) != 0)
		begin
			if ($sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
				f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]) == 14)
			begin
				req.op = l2_op_t'(f[0][1:0]);
				req.unit = unit_t'(f[1][0]);
				req.core = f[2][0];
				req.l1_way = f[3][0];
				req.address = f[4][addr_bits - 1:0];
				req.data = f[5];
				req.is_fill = f[6][0];
				// Core and op come back unchanged from the request
				exp.core = req.core;
				exp.op = req.op;
				exp.hit = f[8][0];
				exp.data = f[9];
				exp.writeback = f[10][0];
				exp.writeback_address = f[11][addr_bits - 1:0];
				exp.writeback_data = f[12];
				exp.l1_had_line = f[13][0];
				stim_request.push_back(req);
				stim_expected.push_back(exp);
				stim_burst.push_back(f[7][0]);
			end
		end
		$fclose(fd);
		line_count = stim_request.size();
		cycle_limit = 10 * line_count + 100;
	endtask

	// Ready is high three cycles in four
	// The idle draw sets the gap before the next request
	always @(posedge clk)
	begin
		response_ready <= take_random_bit() | take_random_bit();
		idle_draw <= {take_random_bit(), take_random_bit()};
	end

	initial
	begin
		load_stimulus();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < line_count; i++)
		begin
			// Burst lines follow their predecessor with no idle cycle
			if (!stim_burst[i] && idle_draw != 2'b00)
			begin
				request_valid <= 1'b0;
				repeat (idle_draw) @(posedge clk);
			end
			request <= stim_request[i];
			request_valid <= 1'b1;
			expected_queue.push_back(stim_expected[i]);
			@(posedge clk);
			while (!request_ready)
				@(posedge clk);
		end
		request_valid <= 1'b0;
		wait (responses_seen == line_count);
		// A few more cycles so that a stray extra response gets caught
		repeat (10) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Responses are compared in order at the edge that transfers them
	always @(posedge clk)
	begin
		l2_response_t expected;
		string mismatch;
		if (!reset && response_valid && response_ready)
		begin
			assert (expected_queue.size() != 0)
			else
			begin
				$display("A response arrived at %0t ns with no request outstanding", $time);
				$display("*** TEST FAILED ***");
				$fatal(1);
			end
			expected = expected_queue.pop_front();
			mismatch = describe_mismatch(response, expected);
			responses_seen++;
			assert (mismatch.len() == 0)
			else
			begin
				$display("[ERROR] %0t ns: response %0d, %s", $time, responses_seen, mismatch);
				$display("*** TEST FAILED ***");
				$fatal(1);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d of %0d responses received",
				cycle_count, responses_seen, line_count);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end
endmodule

/* testbench/l2_stimulus.txt */
# op unit core l1_way address data is_fill burst | expected hit data writeback
# writeback_address writeback_data l1_had_line (hex; op 0 load 1 store 2 flush 3 dinvalidate)
0 1 0 0 101 00000000 0 0 0 00000000 0 000 00000000 0
0 1 0 0 101 11110101 1 0 0 11110101 0 000 00000000 0
0 1 0 0 101 00000000 0 0 1 11110101 0 000 00000000 0
1 1 0 0 101 22220101 0 0 1 22220101 0 000 00000000 0
0 1 0 0 101 00000000 0 1 1 22220101 0 000 00000000 0
1 1 0 0 102 aaaa0102 0 0 0 aaaa0102 0 000 00000000 0
1 1 0 0 102 aaaa0102 1 0 0 aaaa0102 0 000 00000000 0
0 1 1 1 202 bbbb0202 1 0 0 bbbb0202 0 000 00000000 0
0 1 0 0 302 cccc0302 1 0 0 cccc0302 1 102 aaaa0102 0
0 0 0 0 402 dddd0402 1 0 0 dddd0402 0 000 00000000 0
0 1 1 0 202 00000000 0 0 0 00000000 0 000 00000000 0
0 0 1 0 302 00000000 0 0 1 cccc0302 0 000 00000000 0
2 1 0 0 101 00000000 0 0 1 22220101 1 101 22220101 0
2 1 0 0 101 00000000 0 1 1 22220101 0 000 00000000 0
2 1 0 0 501 00000000 0 0 0 00000000 0 000 00000000 0
0 1 0 1 103 33330103 1 0 0 33330103 0 000 00000000 0
3 1 0 0 103 00000000 0 0 1 33330103 0 000 00000000 1
0 1 0 0 103 00000000 0 1 0 00000000 0 000 00000000 0
0 1 0 0 103 44440103 1 0 0 44440103 0 000 00000000 0
3 1 1 0 103 00000000 0 0 1 44440103 0 000 00000000 0
0 0 0 0 104 55550104 1 0 0 55550104 0 000 00000000 0
3 1 0 0 104 00000000 0 0 1 55550104 0 000 00000000 0
1 1 1 0 302 66660302 0 0 1 66660302 0 000 00000000 0
0 1 1 1 302 00000000 0 1 1 66660302 0 000 00000000 0
2 0 1 0 302 00000000 0 1 1 66660302 1 302 66660302 0
3 1 1 0 302 00000000 0 1 1 66660302 0 000 00000000 1
0 1 1 0 302 00000000 0 1 0 00000000 0 000 00000000 0

/* tb.f */
source/l2_config_pkg.sv
source/l2_request_pkg.sv
source/l2_request_in.sv
source/l2_cache_tag.sv
source/l2_cache_dir.sv
source/l2_cache_read.sv
source/l2_cache.sv
testbench/l2_cache_asserts.sv
testbench/l2_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and pass only if the pass message shows up
verilator --binary --timing -Wno-fatal -f tb.f --top-module l2_cache_tb -o l2_cache_sim \
	&& ./obj_dir/l2_cache_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
